// ==== compile.f ====
hw/radio_pkg.sv
hw/symbol_queue.sv
hw/qpsk_mapper.sv
hw/radio_ctrl_regs.sv
hw/radio_core_top.sv
verif/tb_radio_core.sv

// ==== Makefile ====
# Verilator build and run of the radio core testbench

VERILATOR ?= verilator
TOP       ?= tb_radio_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_radio_core.sv ====
/* Radio core testbench */

`timescale 1ns/100ps
`default_nettype none

module tb_radio_core;

   localparam logic [7:0] SR_BASE    = 8'hA0;
   localparam int         SYM_DEPTH  = 8;
   localparam int         CLK_PERIOD = 20;
   localparam int         MAX_SYMS   = 16;    // longest stream in the table
   localparam int         WD_MARGIN  = 500;

   typedef enum {OP_WR, OP_IDLE, OP_RB, OP_FP_IN, OP_MISC_IN, OP_FP_OUT, OP_FP_DDR,
                 OP_MISC_OUT, OP_LED, OP_STREAM, OP_CREDIT, OP_STOP} op_e;

   typedef struct {
      op_e         op;
      logic [7:0]  arg;    // address, cycles or symbol count
      logic [31:0] data;
      logic [63:0] exp;
   } step_t;

   logic                               radio_clk;
   logic                               i_rst;
   logic                               i_set_stb;
   logic [radio_pkg::SET_ADDR_W-1:0]   i_set_addr;
   logic [radio_pkg::SET_DATA_W-1:0]   i_set_data;
   radio_pkg::rb_addr_e                i_rb_addr;
   logic [radio_pkg::RB_DATA_W-1:0]    o_rb_data;
   logic                               i_sym_valid;
   logic [radio_pkg::SYM_W-1:0]        i_sym_data;
   logic                               o_sym_credit;
   radio_pkg::sample_t                 o_tx_sample;
   logic [radio_pkg::GPIO_W-1:0]       i_fp_gpio_in;
   logic [radio_pkg::GPIO_W-1:0]       o_fp_gpio_out;
   logic [radio_pkg::GPIO_W-1:0]       o_fp_gpio_ddr;
   logic [radio_pkg::MISC_W-1:0]       i_misc_in;
   logic [radio_pkg::MISC_W-1:0]       o_misc_out;
   logic [2:0]                         o_radio_led;

   step_t                              steps[$];
   logic [radio_pkg::SYM_W-1:0]        exp_q[$];    // symbols sent, not yet seen
   logic [31:0]                        lfsr;
   int                                 sent_total;
   int                                 credit_cnt;
   int                                 max_rate;
   logic                               table_ready;
   logic [15:0]                        sh_rate;     // host copy of sym_rate
   logic [radio_pkg::IQ_W-2:0]         sh_ampl;

   radio_core_top #(
      .SR_BASE   (SR_BASE),
      .SYM_DEPTH (SYM_DEPTH)
   ) u_radio_core_top (
      .radio_clk     (radio_clk),
      .i_rst         (i_rst),
      .i_set_stb     (i_set_stb),
      .i_set_addr    (i_set_addr),
      .i_set_data    (i_set_data),
      .i_rb_addr     (i_rb_addr),
      .o_rb_data     (o_rb_data),
      .i_sym_valid   (i_sym_valid),
      .i_sym_data    (i_sym_data),
      .o_sym_credit  (o_sym_credit),
      .o_tx_sample   (o_tx_sample),
      .i_fp_gpio_in  (i_fp_gpio_in),
      .o_fp_gpio_out (o_fp_gpio_out),
      .o_fp_gpio_ddr (o_fp_gpio_ddr),
      .i_misc_in     (i_misc_in),
      .o_misc_out    (o_misc_out),
      .o_radio_led   (o_radio_led)
   );

   always #(CLK_PERIOD/2) radio_clk = ~radio_clk;

   // credits back from the DUT, counted on the falling edge
   always @(negedge radio_clk) begin
      if (i_rst) credit_cnt <= 0;
      else if (o_sym_credit) credit_cnt <= credit_cnt + 1;
   end

   // --------------------
   // helpers and checks
   // --------------------
   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_sample(input string name, input radio_pkg::sample_t got,
                               input radio_pkg::sample_t exp);
      if (got !== exp)
         stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_rb(input string name, input logic [radio_pkg::RB_DATA_W-1:0] got,
                           input logic [radio_pkg::RB_DATA_W-1:0] exp);
      if (got !== exp)
         stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_bits(input string name, input logic [radio_pkg::MISC_W-1:0] got,
                             input logic [radio_pkg::MISC_W-1:0] exp);
      if (got !== exp)
         stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // bit 1 signs I, bit 0 signs Q, a set bit means negative
   function automatic radio_pkg::sample_t qpsk_point(input logic [1:0] sym,
                                                     input logic [radio_pkg::IQ_W-2:0] amp);
      radio_pkg::sample_t      s;
      logic [radio_pkg::IQ_W-1:0] plus;
      logic [radio_pkg::IQ_W-1:0] minus;
      plus  = {1'b0, amp};
      minus = ~plus + 1'b1;
      s.i   = sym[1] ? minus : plus;
      s.q   = sym[0] ? minus : plus;
      return s;
   endfunction

   task automatic set_write(input logic [7:0] addr, input logic [31:0] data);
      i_set_addr = addr;
      i_set_data = data;
      i_set_stb  = 1'b1;
      if (addr == SR_BASE + radio_pkg::SR_SYM_RATE) sh_rate = data[15:0];
      if (addr == SR_BASE + radio_pkg::SR_AMPL) sh_ampl = data[radio_pkg::IQ_W-2:0];
      @(negedge radio_clk);
      i_set_stb = 1'b0;
   endtask

   // one symbol per cycle while credits last
   task automatic send_symbols(input int n);
      logic [1:0] sym;
      int         left;
      left = n;
      while (left > 0) begin
         if (SYM_DEPTH - sent_total + credit_cnt > 0) begin
            lfsr = lfsr_step(lfsr);
            sym[1] = lfsr[0];
            lfsr = lfsr_step(lfsr);
            sym[0] = lfsr[0];
            i_sym_valid = 1'b1;
            i_sym_data  = sym;
            exp_q.push_back(sym);
            sent_total++;
            left--;
         end else begin
            i_sym_valid = 1'b0;
         end
         @(negedge radio_clk);
      end
      i_sym_valid = 1'b0;
   endtask

   task automatic expect_stream(input int n);
      radio_pkg::sample_t exp;
      while (o_tx_sample == '0) @(negedge radio_clk);
      for (int k = 0; k < n; k++) begin
         exp = qpsk_point(exp_q.pop_front(), sh_ampl);
         repeat (sh_rate) begin
            check_sample("o_tx_sample", o_tx_sample, exp);
            @(negedge radio_clk);
         end
      end
      check_sample("o_tx_sample", o_tx_sample, '0);   // drained
   endtask

   task automatic credit_flow(input int n, input logic [31:0] ctrl);
      int base;
      base = credit_cnt;
      send_symbols(n);
      repeat (4) @(negedge radio_clk);
      check_bits("o_sym_credit count", credit_cnt - base, 0);
      check_sample("o_tx_sample", o_tx_sample, '0);
      set_write(SR_BASE + radio_pkg::SR_CTRL, ctrl);
      expect_stream(n);
      repeat (2) @(negedge radio_clk);
      check_bits("o_sym_credit count", credit_cnt - base, n);
   endtask

   task automatic stop_mid_stream(input int n, input logic [31:0] ctrl);
      radio_pkg::sample_t exp;
      fork
         send_symbols(n);
         begin
            while (o_tx_sample == '0) @(negedge radio_clk);
            exp = qpsk_point(exp_q.pop_front(), sh_ampl);
            check_sample("o_tx_sample", o_tx_sample, exp);
            check_bits("o_radio_led", o_radio_led, 3'b101);
            set_write(SR_BASE + radio_pkg::SR_CTRL, ctrl & ~32'h1);   // tx_run off
            for (int c = 1; c < sh_rate; c++) begin
               check_sample("o_tx_sample", o_tx_sample, exp);
               check_bits("o_radio_led", o_radio_led, 3'b110);
               @(negedge radio_clk);
            end
            repeat (2 * sh_rate) begin
               check_sample("o_tx_sample", o_tx_sample, '0);
               @(negedge radio_clk);
            end
            check_bits("o_radio_led", o_radio_led, 3'b101);
            set_write(SR_BASE + radio_pkg::SR_CTRL, ctrl);   // resume, rest of queue
            expect_stream(n - 1);
            @(negedge radio_clk);
            check_bits("o_radio_led", o_radio_led, 3'b101);
         end
      join
   endtask

   // --------------------
   // stimulus table
   // --------------------
   task automatic add_step(input op_e op, input logic [7:0] arg, input logic [31:0] data,
                           input logic [63:0] exp);
      step_t s;
      s.op   = op;
      s.arg  = arg;
      s.data = data;
      s.exp  = exp;
      steps.push_back(s);
      if (op == OP_WR && arg == SR_BASE + radio_pkg::SR_SYM_RATE && int'(data[15:0]) > max_rate)
         max_rate = int'(data[15:0]);
   endtask

   task automatic build_table();
      add_step(OP_WR, SR_BASE + radio_pkg::SR_FP_OUT, 32'h0000_0a5c, '0);
      add_step(OP_FP_OUT, 8'd0, '0, 64'h0a5c);
      add_step(OP_WR, SR_BASE + radio_pkg::SR_FP_DDR, 32'h0000_f3c3, '0);
      add_step(OP_FP_DDR, 8'd0, '0, 64'h03c3);
      add_step(OP_WR, SR_BASE + radio_pkg::SR_MISC_OUT, 32'hdead_beef, '0);
      add_step(OP_MISC_OUT, 8'd0, '0, 64'hdead_beef);
      add_step(OP_WR, SR_BASE - 8'd1, 32'hffff_ffff, '0);   // just below the window
      add_step(OP_WR, SR_BASE + 8'd11, 32'hffff_ffff, '0);  // above it, low bits alias fp_out
      add_step(OP_FP_OUT, 8'd0, '0, 64'h0a5c);
      add_step(OP_FP_DDR, 8'd0, '0, 64'h03c3);
      add_step(OP_MISC_OUT, 8'd0, '0, 64'hdead_beef);
      add_step(OP_WR, SR_BASE + radio_pkg::SR_SYM_RATE, 32'd3, '0);
      add_step(OP_WR, SR_BASE + radio_pkg::SR_AMPL, 32'h1234, '0);
      add_step(OP_RB, radio_pkg::RB_TX, '0, 64'h0000_0000_0001_9234);
      add_step(OP_RB, radio_pkg::RB_MISC, '0, 64'hdead_beef_0000_0000);
      add_step(OP_MISC_IN, 8'd0, 32'h1357_9bdf, 64'hdead_beef_1357_9bdf);
      add_step(OP_RB, radio_pkg::RB_FP, '0, 64'h0000_03c3_0a5c_0000);
      add_step(OP_FP_IN, 8'd0, 32'h0000_096e, 64'h0000_03c3_0a5c_096e);
      add_step(OP_WR, SR_BASE + radio_pkg::SR_CTRL, 32'd1, '0);
      add_step(OP_STREAM, 8'd16, '0, '0);
      add_step(OP_WR, SR_BASE + radio_pkg::SR_SYM_RATE, 32'd2, '0);
      add_step(OP_WR, SR_BASE + radio_pkg::SR_CTRL, 32'd0, '0);
      add_step(OP_CREDIT, 8'(SYM_DEPTH), 32'd1, '0);
      add_step(OP_WR, SR_BASE + radio_pkg::SR_SYM_RATE, 32'd3, '0);
      add_step(OP_WR, SR_BASE + radio_pkg::SR_CTRL, 32'd3, '0);
      add_step(OP_IDLE, 8'd1, '0, '0);   // leds lag the control bits by one
      add_step(OP_LED, 8'd0, '0, 64'h5);
      add_step(OP_STOP, 8'd4, 32'd3, '0);
   endtask

   task automatic run_step(input step_t s);
      case (s.op)
         OP_WR:       set_write(s.arg, s.data);
         OP_IDLE:     repeat (s.arg) @(negedge radio_clk);
         OP_RB: begin
            i_rb_addr = radio_pkg::rb_addr_e'(s.arg);
            @(negedge radio_clk);
            check_rb("o_rb_data", o_rb_data, s.exp);
         end
         OP_FP_IN, OP_MISC_IN: begin
            if (s.op == OP_FP_IN) i_fp_gpio_in = s.data[radio_pkg::GPIO_W-1:0];
            else i_misc_in = s.data;
            @(negedge radio_clk);
            if (o_rb_data === s.exp)
               stop_on_error("readback showed a pin change after only one cycle");
            @(negedge radio_clk);
            check_rb("o_rb_data", o_rb_data, s.exp);
         end
         OP_FP_OUT:   check_bits("o_fp_gpio_out", o_fp_gpio_out, s.exp[31:0]);
         OP_FP_DDR:   check_bits("o_fp_gpio_ddr", o_fp_gpio_ddr, s.exp[31:0]);
         OP_MISC_OUT: check_bits("o_misc_out", o_misc_out, s.exp[31:0]);
         OP_LED:      check_bits("o_radio_led", o_radio_led, s.exp[31:0]);
         OP_STREAM: begin
            fork
               send_symbols(s.arg);
               expect_stream(s.arg);
            join
         end
         OP_CREDIT:   credit_flow(s.arg, s.data);
         OP_STOP:     stop_mid_stream(s.arg, s.data);
         default:     stop_on_error("unknown operation in the stimulus table");
      endcase
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      radio_clk    = 1'b0;
      i_rst        = 1'b1;
      i_set_stb    = 1'b0;
      i_set_addr   = '0;
      i_set_data   = '0;
      i_rb_addr    = radio_pkg::RB_FP;
      i_sym_valid  = 1'b0;
      i_sym_data   = '0;
      i_fp_gpio_in = '0;
      i_misc_in    = '0;
      lfsr         = 32'h0074daf5;
      sent_total   = 0;
      max_rate     = 1;
      sh_rate      = '0;
      sh_ampl      = '0;
      table_ready  = 1'b0;
      build_table();
      table_ready  = 1'b1;
      repeat (3) @(negedge radio_clk);
      i_rst = 1'b0;

      check_sample("o_tx_sample", o_tx_sample, '0);
      check_rb("o_rb_data", o_rb_data, '0);
      check_bits("o_sym_credit", o_sym_credit, 0);
      check_bits("o_radio_led", o_radio_led, 0);
      check_bits("o_fp_gpio_out", o_fp_gpio_out, 0);
      check_bits("o_fp_gpio_ddr", o_fp_gpio_ddr, 0);
      check_bits("o_misc_out", o_misc_out, 0);

      foreach (steps[k]) run_step(steps[k]);

      repeat (4) @(negedge radio_clk);
      if (credit_cnt != sent_total) begin
         stop_on_error($sformatf("%0d symbols sent but %0d credits returned",
                                 sent_total, credit_cnt));
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

   // watchdog, scaled from the table and the slowest symbol rate
   initial begin
      int limit;
      wait (table_ready);
      limit = steps.size() * MAX_SYMS * (max_rate + 2) + WD_MARGIN;
      repeat (limit) @(posedge radio_clk);
      stop_on_error($sformatf("run did not finish within %0d clock cycles", limit));
   end

endmodule

`default_nettype wire

// ==== hw/radio_core_top.sv ====
/* Radio core top level */

`timescale 1ns/100ps
`default_nettype none

module radio_core_top #(
   parameter logic [radio_pkg::SET_ADDR_W-1:0] SR_BASE = 8'd160,
   parameter int SYM_DEPTH = 8
) (
   input  logic                             radio_clk,
   input  logic                             i_rst,
   // settings bus
   input  logic                             i_set_stb,
   input  logic [radio_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  logic [radio_pkg::SET_DATA_W-1:0] i_set_data,
   input  radio_pkg::rb_addr_e              i_rb_addr,
   output logic [radio_pkg::RB_DATA_W-1:0]  o_rb_data,
   // symbol input, credit counted
   input  logic                             i_sym_valid,
   input  logic [radio_pkg::SYM_W-1:0]      i_sym_data,
   output logic                             o_sym_credit,
   output radio_pkg::sample_t               o_tx_sample,
   // front panel and misc pins
   input  logic [radio_pkg::GPIO_W-1:0]     i_fp_gpio_in,
   output logic [radio_pkg::GPIO_W-1:0]     o_fp_gpio_out,
   output logic [radio_pkg::GPIO_W-1:0]     o_fp_gpio_ddr,
   input  logic [radio_pkg::MISC_W-1:0]     i_misc_in,
   output logic [radio_pkg::MISC_W-1:0]     o_misc_out,
   output logic [2:0]                       o_radio_led
);

   logic                            tx_run;
   logic [15:0]                     sym_rate;
   logic [radio_pkg::IQ_W-2:0]      ampl;
   logic                            tx_active;
   logic                            q_valid;
   logic [radio_pkg::SYM_W-1:0]     q_data;
   logic                            q_pop;

   // --------------------
   // control registers
   // --------------------
   radio_ctrl_regs #(
      .SR_BASE (SR_BASE)
   ) u_radio_ctrl_regs (
      .radio_clk     (radio_clk),
      .i_rst         (i_rst),
      .i_set_stb     (i_set_stb),
      .i_set_addr    (i_set_addr),
      .i_set_data    (i_set_data),
      .i_rb_addr     (i_rb_addr),
      .i_fp_gpio_in  (i_fp_gpio_in),
      .i_misc_in     (i_misc_in),
      .i_tx_active   (tx_active),
      .o_rb_data     (o_rb_data),
      .o_fp_gpio_out (o_fp_gpio_out),
      .o_fp_gpio_ddr (o_fp_gpio_ddr),
      .o_misc_out    (o_misc_out),
      .o_tx_run      (tx_run),
      .o_sym_rate    (sym_rate),
      .o_ampl        (ampl),
      .o_radio_led   (o_radio_led)
   );

   // --------------------
   // transmit path
   // --------------------
   symbol_queue #(
      .SYM_DEPTH (SYM_DEPTH)
   ) u_symbol_queue (
      .radio_clk   (radio_clk),
      .i_rst       (i_rst),
      .i_sym_valid (i_sym_valid),
      .i_sym_data  (i_sym_data),
      .i_pop       (q_pop),
      .o_valid     (q_valid),
      .o_data      (q_data),
      .o_credit    (o_sym_credit)
   );

   qpsk_mapper u_qpsk_mapper (
      .radio_clk   (radio_clk),
      .i_rst       (i_rst),
      .i_valid     (q_valid),
      .i_data      (q_data),
      .i_tx_run    (tx_run),
      .i_sym_rate  (sym_rate),
      .i_ampl      (ampl),
      .o_pop       (q_pop),
      .o_sample    (o_tx_sample),
      .o_tx_active (tx_active)
   );

endmodule

`default_nettype wire

// ==== hw/radio_ctrl_regs.sv ====
/* Radio settings and readback registers */

`timescale 1ns/100ps
`default_nettype none

module radio_ctrl_regs #(
   parameter logic [radio_pkg::SET_ADDR_W-1:0] SR_BASE = 8'd160
) (
   input  logic                             radio_clk,
   input  logic                             i_rst,
   input  logic                             i_set_stb,
   input  logic [radio_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  logic [radio_pkg::SET_DATA_W-1:0] i_set_data,
   input  radio_pkg::rb_addr_e              i_rb_addr,
   input  logic [radio_pkg::GPIO_W-1:0]     i_fp_gpio_in,
   input  logic [radio_pkg::MISC_W-1:0]     i_misc_in,
   input  logic                             i_tx_active,
   output logic [radio_pkg::RB_DATA_W-1:0]  o_rb_data,
   output logic [radio_pkg::GPIO_W-1:0]     o_fp_gpio_out,
   output logic [radio_pkg::GPIO_W-1:0]     o_fp_gpio_ddr,
   output logic [radio_pkg::MISC_W-1:0]     o_misc_out,
   output logic                             o_tx_run,
   output logic [15:0]                      o_sym_rate,
   output logic [radio_pkg::IQ_W-2:0]       o_ampl,
   output logic [2:0]                       o_radio_led
);

   localparam int GPIO_PAD = 16 - radio_pkg::GPIO_W;
   localparam int FP_PAD   = radio_pkg::RB_DATA_W - 48;
   localparam int TX_PAD   = radio_pkg::RB_DATA_W - 16 - (radio_pkg::IQ_W - 1);

   logic [radio_pkg::SET_ADDR_W-1:0] set_off;
   logic                             set_hit;
   logic                             rx_run;
   logic [radio_pkg::GPIO_W-1:0]     fp_in_r;
   logic [radio_pkg::MISC_W-1:0]     misc_in_r;

   // wraps mod 256, so anything below the base lands out of range too
   assign set_off = i_set_addr - SR_BASE;
   assign set_hit = i_set_stb && (set_off <= radio_pkg::SR_MISC_OUT);

   // --------------------
   // settings writes
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_tx_run      <= 1'b0;
         rx_run        <= 1'b0;
         o_sym_rate    <= '0;
         o_ampl        <= '0;
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
         o_misc_out    <= '0;
      end else if (set_hit) begin
         case (set_off)
            radio_pkg::SR_CTRL: begin
               o_tx_run <= i_set_data[0];
               rx_run   <= i_set_data[1];
            end
            radio_pkg::SR_SYM_RATE: o_sym_rate    <= i_set_data[15:0];
            radio_pkg::SR_AMPL:     o_ampl        <= i_set_data[radio_pkg::IQ_W-2:0];
            radio_pkg::SR_FP_OUT:   o_fp_gpio_out <= i_set_data[radio_pkg::GPIO_W-1:0];
            radio_pkg::SR_FP_DDR:   o_fp_gpio_ddr <= i_set_data[radio_pkg::GPIO_W-1:0];
            radio_pkg::SR_MISC_OUT: o_misc_out    <= i_set_data[radio_pkg::MISC_W-1:0];
            default: ;
         endcase
      end
   end

   // pin inputs, one stage before readback
   always_ff @(posedge radio_clk) begin
      fp_in_r   <= i_fp_gpio_in;
      misc_in_r <= i_misc_in;
   end

   // --------------------
   // readback mux
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rb_data <= '0;
      end else begin
         case (i_rb_addr)
            radio_pkg::RB_FP: begin
               o_rb_data <= {{FP_PAD{1'b0}},
                             {GPIO_PAD{1'b0}}, o_fp_gpio_ddr,
                             {GPIO_PAD{1'b0}}, o_fp_gpio_out,
                             {GPIO_PAD{1'b0}}, fp_in_r};
            end
            radio_pkg::RB_MISC: o_rb_data <= {o_misc_out, misc_in_r};
            radio_pkg::RB_TX:   o_rb_data <= {{TX_PAD{1'b0}}, o_sym_rate, o_ampl};
            default:            o_rb_data <= '0;   // unmapped address
         endcase
      end
   end

   // leds are {RX, TXRX_TX, TXRX_RX}
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_radio_led <= 3'b000;
      end else begin
         o_radio_led[2] <= rx_run;
         o_radio_led[1] <= i_tx_active;
         o_radio_led[0] <= rx_run & ~i_tx_active;   // txrx port free for rx
      end
   end

endmodule

`default_nettype wire

// ==== hw/qpsk_mapper.sv ====
/* QPSK symbol mapper */

`timescale 1ns/100ps
`default_nettype none

module qpsk_mapper (
   input  logic                        radio_clk,
   input  logic                        i_rst,
   input  logic                        i_valid,
   input  logic [radio_pkg::SYM_W-1:0] i_data,
   input  logic                        i_tx_run,
   input  logic [15:0]                 i_sym_rate,
   input  logic [radio_pkg::IQ_W-2:0]  i_ampl,
   output logic                        o_pop,
   output radio_pkg::sample_t          o_sample,
   output logic                        o_tx_active
);

   radio_pkg::map_state_e        state;
   logic [15:0]                  hold_cnt;   // cycles left, 1 on the last one
   logic [15:0]                  hold_len;
   logic                         boundary;
   logic [radio_pkg::IQ_W-1:0]   pos_amp;
   logic [radio_pkg::IQ_W-1:0]   neg_amp;
   radio_pkg::sample_t           mapped;

   // a rate of zero would never end a symbol
   assign hold_len = (i_sym_rate == 16'd0) ? 16'd1 : i_sym_rate;

   // --------------------
   // symbol to I/Q
   // --------------------
   assign pos_amp  = {1'b0, i_ampl};
   assign neg_amp  = -pos_amp;
   assign mapped.i = i_data[1] ? neg_amp : pos_amp;   // bit 1 is I sign
   assign mapped.q = i_data[0] ? neg_amp : pos_amp;   // bit 0 is Q sign

   // last hold cycle, next symbol can follow with no gap
   assign boundary = (state == radio_pkg::MAP_IDLE) ||
                     (state == radio_pkg::MAP_HOLD && hold_cnt == 16'd1);
   assign o_pop    = boundary && i_tx_run && i_valid;

   // --------------------
   // FSM
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         state    <= radio_pkg::MAP_IDLE;
         hold_cnt <= '0;
         o_sample <= '0;
      end else begin
         if (o_pop) begin
            state    <= radio_pkg::MAP_HOLD;
            hold_cnt <= hold_len;
            o_sample <= mapped;
         end else if (boundary) begin
            // queue dry or run cleared, only after the full hold
            state    <= radio_pkg::MAP_IDLE;
            hold_cnt <= '0;
            o_sample <= '0;
         end else begin
            hold_cnt <= hold_cnt - 1'b1;
         end
      end
   end

   assign o_tx_active = (state == radio_pkg::MAP_HOLD);

endmodule

`default_nettype wire

// ==== hw/symbol_queue.sv ====
/* Credit counted symbol FIFO */

`timescale 1ns/100ps
`default_nettype none

module symbol_queue #(
   parameter int SYM_DEPTH = 8   // power of two
) (
   input  logic                        radio_clk,
   input  logic                        i_rst,
   input  logic                        i_sym_valid,
   input  logic [radio_pkg::SYM_W-1:0] i_sym_data,
   input  logic                        i_pop,
   output logic                        o_valid,
   output logic [radio_pkg::SYM_W-1:0] o_data,
   output logic                        o_credit
);

   localparam int AW = $clog2(SYM_DEPTH);

   logic [radio_pkg::SYM_W-1:0] mem [SYM_DEPTH];
   logic [AW:0]                 wr_ptr;   // extra bit tells full from empty
   logic [AW:0]                 rd_ptr;

   // sender holds credits, so a push never finds the buffer full
   always_ff @(posedge radio_clk) begin
      if (i_sym_valid) begin
         mem[wr_ptr[AW-1:0]] <= i_sym_data;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         o_credit <= 1'b0;
      end else begin
         if (i_sym_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (i_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         o_credit <= i_pop;   // one credit back per entry taken
      end
   end

   assign o_valid = (wr_ptr != rd_ptr);
   assign o_data  = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

// ==== hw/radio_pkg.sv ====
/* Radio core shared definitions */

`default_nettype none

package radio_pkg;

   // --------------------
   // bus and data widths
   // --------------------
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int RB_DATA_W  = 64;
   localparam int GPIO_W     = 12;   // front-panel pins
   localparam int MISC_W     = 32;
   localparam int SYM_W      = 2;    // one qpsk symbol
   localparam int IQ_W       = 16;

   // one tx sample, I in the upper half
   typedef struct packed {
      logic [IQ_W-1:0] i;
      logic [IQ_W-1:0] q;
   } sample_t;

   // settings register offsets from SR_BASE
   typedef enum logic [7:0] {
      SR_CTRL     = 8'd0,   // bit 0 tx_run, bit 1 rx_run
      SR_SYM_RATE = 8'd1,   // clocks per symbol
      SR_AMPL     = 8'd2,
      SR_FP_OUT   = 8'd3,
      SR_FP_DDR   = 8'd4,
      SR_MISC_OUT = 8'd5
   } set_reg_e;

   // readback addresses
   typedef enum logic [7:0] {
      RB_FP   = 8'd0,   // {ddr, out, in} in 16-bit lanes
      RB_MISC = 8'd1,   // {misc_out, misc_in}
      RB_TX   = 8'd2    // {sym_rate, ampl}
   } rb_addr_e;

   // mapper FSM
   typedef enum logic {
      MAP_IDLE = 1'b0,
      MAP_HOLD = 1'b1
   } map_state_e;

endpackage

`default_nettype wire
